/* include/rsv_sched_defines.svh */
`ifndef RSV_SCHED_DEFINES_SVH
`define RSV_SCHED_DEFINES_SVH

// scheduler sizing
`define RSV_ENTRY_NUM 4
`define RSV_IDX_W     2  // log2 of RSV_ENTRY_NUM

// operand and instruction widths
`define RSV_RNID_W    5
`define RSV_CMT_ID_W  4

`define RSV_WB_NUM    2  // writeback buses seen by every entry

`endif

/* rsv_sched.f */
+incdir+include
rtl/rsv_data_pkg.sv
rtl/rsv_ctrl_pkg.sv
rtl/wakeup_match.sv
rtl/rsv_entry.sv
rtl/rsv_alloc.sv
rtl/rsv_pick.sv
rtl/rsv_sched_top.sv
test/tb_rsv_sched.sv

/* rtl/rsv_alloc.sv */
`timescale 1ns/10ps
`include "rsv_sched_defines.svh"

module rsv_alloc (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_disp,
  input  rsv_ctrl_pkg::entry_vec_t i_busy,
  output rsv_ctrl_pkg::entry_vec_t o_put,
  output logic                     o_full
);

  import rsv_ctrl_pkg::*;

  entry_idx_t w_free_idx;
  logic       w_free_found;

  // walk down so the lowest free index is the last one written
  always_comb begin
    w_free_idx   = '0;
    w_free_found = 1'b0;
    for (int i = `RSV_ENTRY_NUM - 1; i >= 0; i--) begin
      if (!i_busy[i]) begin
        w_free_idx   = entry_idx_t'(i);
        w_free_found = 1'b1;
      end
    end
  end

  assign o_put  = (i_disp & w_free_found) ? (entry_vec_t'(1) << w_free_idx) : '0;
  assign o_full = &i_busy;

  // the dispatch side sees o_full and must hold off
  a_no_disp_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp |-> !o_full)
    else $error("rsv_alloc: dispatch while the station is full");

endmodule

/* rtl/rsv_ctrl_pkg.sv */
`include "rsv_sched_defines.svh"

package rsv_ctrl_pkg;

  typedef logic [`RSV_IDX_W-1:0]     entry_idx_t;
  typedef logic [`RSV_ENTRY_NUM-1:0] entry_vec_t;  // bit i belongs to entry i

  // life of one entry
  typedef enum logic [1:0] {
    ST_FREE   = 2'd0,
    ST_WAIT   = 2'd1,  // holding an instruction, not yet issued
    ST_ISSUED = 2'd2,
    ST_DONE   = 2'd3   // one cycle, reported as retire
  } entry_state_t;

endpackage

/* rtl/rsv_data_pkg.sv */
`include "rsv_sched_defines.svh"

package rsv_data_pkg;

  // physical register tag after rename
  typedef logic [`RSV_RNID_W-1:0] rnid_t;

  typedef logic [`RSV_CMT_ID_W-1:0] cmt_id_t;  // commit id carried to retire

  // a tag only matches within its own register file
  typedef enum logic {
    CLS_INT = 1'b0,
    CLS_FP  = 1'b1
  } reg_class_t;

  typedef logic [`RSV_WB_NUM-1:0] wb_vld_t;  // one valid per writeback bus

endpackage

/* rtl/rsv_entry.sv */
`timescale 1ns/10ps
`include "rsv_sched_defines.svh"

module rsv_entry (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_put,
  input  rsv_data_pkg::cmt_id_t    i_disp_cmt_id,
  input  logic                     i_disp_store,
  input  rsv_data_pkg::rnid_t      i_disp_rd,
  input  logic                     i_disp_rs1_valid,
  input  rsv_data_pkg::rnid_t      i_disp_rs1,
  input  rsv_data_pkg::reg_class_t i_disp_rs1_cls,
  input  logic                     i_disp_rs2_valid,
  input  rsv_data_pkg::rnid_t      i_disp_rs2,
  input  rsv_data_pkg::reg_class_t i_disp_rs2_cls,
  input  rsv_data_pkg::wb_vld_t    i_wb_valid,
  input  rsv_data_pkg::rnid_t      i_wb_rnid [`RSV_WB_NUM],
  input  rsv_data_pkg::reg_class_t i_wb_cls  [`RSV_WB_NUM],
  input  logic                     i_picked,
  input  logic                     i_done,
  input  logic                     i_replay,
  output logic                     o_busy,
  output logic                     o_ready,
  output logic                     o_done,
  output rsv_data_pkg::cmt_id_t    o_cmt_id,
  output rsv_data_pkg::rnid_t      o_rd,
  output logic                     o_store
);

  import rsv_data_pkg::*;
  import rsv_ctrl_pkg::*;

  entry_state_t r_state;
  logic         r_rs1_rdy;
  logic         r_rs2_rdy;

  cmt_id_t      r_cmt_id;
  rnid_t        r_rd;
  logic         r_store;
  logic         r_rs1_valid;
  rnid_t        r_rs1;
  reg_class_t   r_rs1_cls;
  logic         r_rs2_valid;
  rnid_t        r_rs2;
  reg_class_t   r_rs2_cls;

  rnid_t        w_rs1;
  reg_class_t   w_rs1_cls;
  rnid_t        w_rs2;
  reg_class_t   w_rs2_cls;
  logic         w_rs1_hit;
  logic         w_rs2_hit;
  logic         w_rs1_rdy;
  logic         w_rs2_rdy;
  logic         w_opnd_rdy;

  // during a put the incoming tags are compared, so a same-cycle writeback is not lost
  assign w_rs1     = i_put ? i_disp_rs1 : r_rs1;
  assign w_rs1_cls = i_put ? i_disp_rs1_cls : r_rs1_cls;
  assign w_rs2     = i_put ? i_disp_rs2 : r_rs2;
  assign w_rs2_cls = i_put ? i_disp_rs2_cls : r_rs2_cls;

  wakeup_match u_rs1_match (
    .i_rnid     (w_rs1),
    .i_cls      (w_rs1_cls),
    .i_wb_valid (i_wb_valid),
    .i_wb_rnid  (i_wb_rnid),
    .i_wb_cls   (i_wb_cls),
    .o_hit      (w_rs1_hit)
  );

  wakeup_match u_rs2_match (
    .i_rnid     (w_rs2),
    .i_cls      (w_rs2_cls),
    .i_wb_valid (i_wb_valid),
    .i_wb_rnid  (i_wb_rnid),
    .i_wb_cls   (i_wb_cls),
    .o_hit      (w_rs2_hit)
  );

  assign w_rs1_rdy = r_rs1_rdy | w_rs1_hit;
  assign w_rs2_rdy = r_rs2_rdy | w_rs2_hit;

  // a store waits on rs1 only
  assign w_opnd_rdy = (!r_rs1_valid | w_rs1_rdy) &
                      (r_store | !r_rs2_valid | w_rs2_rdy);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state   <= ST_FREE;
      r_rs1_rdy <= 1'b0;
      r_rs2_rdy <= 1'b0;
    end else begin
      case (r_state)
        ST_FREE: begin
          if (i_put) begin
            r_state   <= ST_WAIT;
            r_rs1_rdy <= w_rs1_hit;
            r_rs2_rdy <= w_rs2_hit;
          end
        end
        ST_WAIT: begin
          r_rs1_rdy <= w_rs1_rdy;
          r_rs2_rdy <= w_rs2_rdy;
          if (i_picked) begin
            r_state <= ST_ISSUED;
          end
        end
        ST_ISSUED: begin
          if (i_replay) begin
            r_state <= ST_WAIT;  // replay beats done, ready bits stay
          end else if (i_done) begin
            r_state <= ST_DONE;
          end
        end
        ST_DONE: begin
          r_state <= ST_FREE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_cmt_id    <= i_disp_cmt_id;
      r_rd        <= i_disp_rd;
      r_store     <= i_disp_store;
      r_rs1_valid <= i_disp_rs1_valid;
      r_rs1       <= i_disp_rs1;
      r_rs1_cls   <= i_disp_rs1_cls;
      r_rs2_valid <= i_disp_rs2_valid;
      r_rs2       <= i_disp_rs2;
      r_rs2_cls   <= i_disp_rs2_cls;
    end
  end

  assign o_busy   = (r_state != ST_FREE);
  assign o_ready  = (r_state == ST_WAIT) & w_opnd_rdy;
  assign o_done   = (r_state == ST_DONE);
  assign o_cmt_id = r_cmt_id;
  assign o_rd     = r_rd;
  assign o_store  = r_store;

  // allocator must only steer dispatch to a free entry
  a_put_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_put |-> !o_busy)
    else $error("rsv_entry: put into a busy entry");

  // picker must only select an entry that reports ready
  a_pick_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_picked |-> o_ready)
    else $error("rsv_entry: picked while not ready");

endmodule

/* rtl/rsv_pick.sv */
`timescale 1ns/10ps
`include "rsv_sched_defines.svh"

module rsv_pick (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  rsv_ctrl_pkg::entry_vec_t i_ready,
  input  rsv_ctrl_pkg::entry_vec_t i_done_st,
  input  rsv_data_pkg::cmt_id_t    i_cmt_id [`RSV_ENTRY_NUM],
  input  rsv_data_pkg::rnid_t      i_rd     [`RSV_ENTRY_NUM],
  input  rsv_ctrl_pkg::entry_vec_t i_store,
  input  logic                     i_done,
  input  rsv_ctrl_pkg::entry_idx_t i_done_idx,
  input  logic                     i_replay,
  input  rsv_ctrl_pkg::entry_idx_t i_replay_idx,
  output rsv_ctrl_pkg::entry_vec_t o_picked,
  output rsv_ctrl_pkg::entry_vec_t o_done_vec,
  output rsv_ctrl_pkg::entry_vec_t o_replay_vec,
  output logic                     o_issue_valid,
  output rsv_ctrl_pkg::entry_idx_t o_issue_idx,
  output rsv_data_pkg::cmt_id_t    o_issue_cmt_id,
  output rsv_data_pkg::rnid_t      o_issue_rd,
  output logic                     o_issue_store,
  output logic                     o_retire_valid,
  output rsv_data_pkg::cmt_id_t    o_retire_cmt_id
);

  import rsv_ctrl_pkg::*;

  entry_idx_t w_retire_idx;

  // lowest ready index wins
  always_comb begin
    o_issue_idx = '0;
    for (int i = `RSV_ENTRY_NUM - 1; i >= 0; i--) begin
      if (i_ready[i]) begin
        o_issue_idx = entry_idx_t'(i);
      end
    end
  end

  assign o_issue_valid  = |i_ready;
  assign o_picked       = o_issue_valid ? (entry_vec_t'(1) << o_issue_idx) : '0;
  assign o_issue_cmt_id = i_cmt_id[o_issue_idx];
  assign o_issue_rd     = i_rd[o_issue_idx];
  assign o_issue_store  = i_store[o_issue_idx];

  assign o_done_vec   = i_done ? (entry_vec_t'(1) << i_done_idx) : '0;
  assign o_replay_vec = i_replay ? (entry_vec_t'(1) << i_replay_idx) : '0;

  // only one entry can sit in ST_DONE, so a plain encoder is enough
  always_comb begin
    w_retire_idx = '0;
    for (int i = 0; i < `RSV_ENTRY_NUM; i++) begin
      if (i_done_st[i]) begin
        w_retire_idx = entry_idx_t'(i);
      end
    end
  end

  assign o_retire_valid  = |i_done_st;
  assign o_retire_cmt_id = i_cmt_id[w_retire_idx];

  // entries reach ST_DONE one done strobe at a time
  a_one_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(i_done_st))
    else $error("rsv_pick: more than one entry in done state");

  // a picked entry leaves ST_WAIT, so it is not ready again next cycle
  a_pick_leaves: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_picked != '0) |=> ((o_picked & $past(o_picked)) == '0))
    else $error("rsv_pick: same entry picked in consecutive cycles");

endmodule

/* rtl/rsv_sched_top.sv */
`timescale 1ns/10ps
`include "rsv_sched_defines.svh"

module rsv_sched_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_disp,
  input  rsv_data_pkg::cmt_id_t    i_disp_cmt_id,
  input  logic                     i_disp_store,
  input  rsv_data_pkg::rnid_t      i_disp_rd,
  input  logic                     i_disp_rs1_valid,
  input  rsv_data_pkg::rnid_t      i_disp_rs1,
  input  rsv_data_pkg::reg_class_t i_disp_rs1_cls,
  input  logic                     i_disp_rs2_valid,
  input  rsv_data_pkg::rnid_t      i_disp_rs2,
  input  rsv_data_pkg::reg_class_t i_disp_rs2_cls,
  input  rsv_data_pkg::wb_vld_t    i_wb_valid,
  input  rsv_data_pkg::rnid_t      i_wb_rnid [`RSV_WB_NUM],
  input  rsv_data_pkg::reg_class_t i_wb_cls  [`RSV_WB_NUM],
  input  logic                     i_done,
  input  rsv_ctrl_pkg::entry_idx_t i_done_idx,
  input  logic                     i_replay,
  input  rsv_ctrl_pkg::entry_idx_t i_replay_idx,
  output logic                     o_full,
  output logic                     o_issue_valid,
  output rsv_ctrl_pkg::entry_idx_t o_issue_idx,
  output rsv_data_pkg::cmt_id_t    o_issue_cmt_id,
  output rsv_data_pkg::rnid_t      o_issue_rd,
  output logic                     o_issue_store,
  output logic                     o_retire_valid,
  output rsv_data_pkg::cmt_id_t    o_retire_cmt_id
);

  import rsv_data_pkg::*;
  import rsv_ctrl_pkg::*;

  entry_vec_t w_put;
  entry_vec_t w_busy;
  entry_vec_t w_ready;
  entry_vec_t w_done_st;
  entry_vec_t w_store;
  entry_vec_t w_picked;
  entry_vec_t w_done_vec;
  entry_vec_t w_replay_vec;
  cmt_id_t    w_cmt_id [`RSV_ENTRY_NUM];
  rnid_t      w_rd     [`RSV_ENTRY_NUM];

  rsv_alloc u_rsv_alloc (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_disp    (i_disp),
    .i_busy    (w_busy),
    .o_put     (w_put),
    .o_full    (o_full)
  );

  for (genvar g = 0; g < `RSV_ENTRY_NUM; g++) begin : g_entry
    rsv_entry u_rsv_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_put            (w_put[g]),
      .i_disp_cmt_id    (i_disp_cmt_id),
      .i_disp_store     (i_disp_store),
      .i_disp_rd        (i_disp_rd),
      .i_disp_rs1_valid (i_disp_rs1_valid),
      .i_disp_rs1       (i_disp_rs1),
      .i_disp_rs1_cls   (i_disp_rs1_cls),
      .i_disp_rs2_valid (i_disp_rs2_valid),
      .i_disp_rs2       (i_disp_rs2),
      .i_disp_rs2_cls   (i_disp_rs2_cls),
      .i_wb_valid       (i_wb_valid),
      .i_wb_rnid        (i_wb_rnid),
      .i_wb_cls         (i_wb_cls),
      .i_picked         (w_picked[g]),
      .i_done           (w_done_vec[g]),
      .i_replay         (w_replay_vec[g]),
      .o_busy           (w_busy[g]),
      .o_ready          (w_ready[g]),
      .o_done           (w_done_st[g]),
      .o_cmt_id         (w_cmt_id[g]),
      .o_rd             (w_rd[g]),
      .o_store          (w_store[g])
    );
  end

  rsv_pick u_rsv_pick (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_ready         (w_ready),
    .i_done_st       (w_done_st),
    .i_cmt_id        (w_cmt_id),
    .i_rd            (w_rd),
    .i_store         (w_store),
    .i_done          (i_done),
    .i_done_idx      (i_done_idx),
    .i_replay        (i_replay),
    .i_replay_idx    (i_replay_idx),
    .o_picked        (w_picked),
    .o_done_vec      (w_done_vec),
    .o_replay_vec    (w_replay_vec),
    .o_issue_valid   (o_issue_valid),
    .o_issue_idx     (o_issue_idx),
    .o_issue_cmt_id  (o_issue_cmt_id),
    .o_issue_rd      (o_issue_rd),
    .o_issue_store   (o_issue_store),
    .o_retire_valid  (o_retire_valid),
    .o_retire_cmt_id (o_retire_cmt_id)
  );

endmodule

/* rtl/wakeup_match.sv */
`timescale 1ns/10ps
`include "rsv_sched_defines.svh"

module wakeup_match (
  input  rsv_data_pkg::rnid_t      i_rnid,
  input  rsv_data_pkg::reg_class_t i_cls,
  input  rsv_data_pkg::wb_vld_t    i_wb_valid,
  input  rsv_data_pkg::rnid_t      i_wb_rnid [`RSV_WB_NUM],
  input  rsv_data_pkg::reg_class_t i_wb_cls  [`RSV_WB_NUM],
  output logic                     o_hit
);

  // any valid bus with the same tag and class wakes the source
  always_comb begin
    o_hit = 1'b0;
    for (int i = 0; i < `RSV_WB_NUM; i++) begin
      if (i_wb_valid[i] && (i_wb_rnid[i] == i_rnid) && (i_wb_cls[i] == i_cls)) begin
        o_hit = 1'b1;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the rsv_sched testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --top-module tb_rsv_sched \
  --Mdir "$BUILD" -o tb_rsv_sched -f rsv_sched.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD/tb_rsv_sched" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the fail message on any mismatch or timeout
if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0

/* test/tb_rsv_sched.sv */
`timescale 1ns/10ps
`include "rsv_sched_defines.svh"

module tb_rsv_sched;

  import rsv_data_pkg::*;
  import rsv_ctrl_pkg::*;

  // one table row, tags are indices into the random tag pool
  typedef struct packed {
    logic [3:0]      test;
    logic            disp;
    cmt_id_t         cmt;
    logic            store;
    rnid_t           rd;
    logic            v1;
    logic [2:0]      t1;
    reg_class_t      c1;
    logic            v2;
    logic [2:0]      t2;
    reg_class_t      c2;
    wb_vld_t         wbv;
    logic [1:0][2:0] wt;
    logic [1:0]      wc;
    logic            done;
    entry_idx_t      didx;
    logic            rep;
    entry_idx_t      ridx;
    logic            exp_iss;  // hand-worked issue expectation
  } step_t;

  logic       i_clk;
  logic       i_reset_n;
  logic       i_disp;
  cmt_id_t    i_disp_cmt_id;
  logic       i_disp_store;
  rnid_t      i_disp_rd;
  logic       i_disp_rs1_valid;
  rnid_t      i_disp_rs1;
  reg_class_t i_disp_rs1_cls;
  logic       i_disp_rs2_valid;
  rnid_t      i_disp_rs2;
  reg_class_t i_disp_rs2_cls;
  wb_vld_t    i_wb_valid;
  rnid_t      i_wb_rnid [`RSV_WB_NUM];
  reg_class_t i_wb_cls  [`RSV_WB_NUM];
  logic       i_done;
  entry_idx_t i_done_idx;
  logic       i_replay;
  entry_idx_t i_replay_idx;
  logic       o_full;
  logic       o_issue_valid;
  entry_idx_t o_issue_idx;
  cmt_id_t    o_issue_cmt_id;
  rnid_t      o_issue_rd;
  logic       o_issue_store;
  logic       o_retire_valid;
  cmt_id_t    o_retire_cmt_id;

  step_t steps [$];
  step_t stg;
  rnid_t p_tag [8];
  int    n_errors = 0;
  int    n_checks = 0;
  int    n_tests = 0;
  int    test_errs = 0;
  int    cycle_cnt = 0;
  int    cycle_limit = 0;
  logic  run_started = 1'b0;

  // reference model of the four entries
  entry_state_t m_state [`RSV_ENTRY_NUM];
  cmt_id_t      m_cmt   [`RSV_ENTRY_NUM];
  rnid_t        m_rd    [`RSV_ENTRY_NUM];
  rnid_t        m_rs1   [`RSV_ENTRY_NUM];
  rnid_t        m_rs2   [`RSV_ENTRY_NUM];
  reg_class_t   m_c1    [`RSV_ENTRY_NUM];
  reg_class_t   m_c2    [`RSV_ENTRY_NUM];
  logic         m_store [`RSV_ENTRY_NUM];
  logic         m_v1    [`RSV_ENTRY_NUM];
  logic         m_v2    [`RSV_ENTRY_NUM];
  logic         m_r1    [`RSV_ENTRY_NUM];
  logic         m_r2    [`RSV_ENTRY_NUM];

  rsv_sched_top u_rsv_sched_top (.*);

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    if (run_started) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
      end
    end
  end

  task automatic stage_dispatch(input cmt_id_t cmt, input logic store, input rnid_t rd,
                                input logic v1, input int t1, input reg_class_t c1,
                                input logic v2, input int t2, input reg_class_t c2);
    stg.disp  = 1'b1;
    stg.cmt   = cmt;
    stg.store = store;
    stg.rd    = rd;
    stg.v1    = v1;
    stg.t1    = 3'(t1);
    stg.c1    = c1;
    stg.v2    = v2;
    stg.t2    = 3'(t2);
    stg.c2    = c2;
  endtask

  task automatic add_writeback(input int bus, input int t, input reg_class_t c);
    stg.wbv[bus] = 1'b1;
    stg.wt[bus]  = 3'(t);
    stg.wc[bus]  = c;
  endtask

  task automatic mark_done(input int idx);
    stg.done = 1'b1;
    stg.didx = entry_idx_t'(idx);
  endtask

  task automatic mark_replay(input int idx);
    stg.rep  = 1'b1;
    stg.ridx = entry_idx_t'(idx);
  endtask

  task automatic push_step(input int test, input logic exp_iss);
    stg.test    = 4'(test);
    stg.exp_iss = exp_iss;
    steps.push_back(stg);
    stg = '0;
  endtask

  function automatic logic wb_hits(input step_t s, input rnid_t tag, input reg_class_t cls);
    for (int b = 0; b < `RSV_WB_NUM; b++) begin
      if (s.wbv[b] && (p_tag[s.wt[b]] == tag) && (s.wc[b] == cls)) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "issue after dispatch";
      2: return "wakeup on writeback";
      3: return "store versus non-store";
      4: return "lowest index first";
      default: return "replay and full";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input int got, input int exp);
    $display("ERROR %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    n_errors++;
    test_errs++;
  endtask

  task automatic check_issue(input logic exp_valid, input entry_idx_t exp_idx,
                             input cmt_id_t exp_cmt, input rnid_t exp_rd,
                             input logic exp_store);
    n_checks++;
    if (o_issue_valid !== exp_valid) begin
      report_mismatch("issue valid", o_issue_valid, exp_valid);
    end else if (exp_valid) begin
      if (o_issue_idx !== exp_idx) report_mismatch("issue idx", o_issue_idx, exp_idx);
      if (o_issue_cmt_id !== exp_cmt) report_mismatch("issue cmt id", o_issue_cmt_id, exp_cmt);
      if (o_issue_rd !== exp_rd) report_mismatch("issue rd", o_issue_rd, exp_rd);
      if (o_issue_store !== exp_store) report_mismatch("issue store", o_issue_store, exp_store);
    end
  endtask

  task automatic check_retire(input logic exp_valid, input cmt_id_t exp_cmt);
    n_checks++;
    if (o_retire_valid !== exp_valid) begin
      report_mismatch("retire valid", o_retire_valid, exp_valid);
    end else if (exp_valid && (o_retire_cmt_id !== exp_cmt)) begin
      report_mismatch("retire cmt id", o_retire_cmt_id, exp_cmt);
    end
  endtask

  task automatic check_full(input logic exp_full);
    n_checks++;
    if (o_full !== exp_full) report_mismatch("full", o_full, exp_full);
  endtask

  task automatic drive_step(input step_t s);
    i_disp           <= s.disp;
    i_disp_cmt_id    <= s.cmt;
    i_disp_store     <= s.store;
    i_disp_rd        <= s.rd;
    i_disp_rs1_valid <= s.v1;
    i_disp_rs1       <= p_tag[s.t1];
    i_disp_rs1_cls   <= s.c1;
    i_disp_rs2_valid <= s.v2;
    i_disp_rs2       <= p_tag[s.t2];
    i_disp_rs2_cls   <= s.c2;
    i_wb_valid       <= s.wbv;
    for (int b = 0; b < `RSV_WB_NUM; b++) begin
      i_wb_rnid[b] <= p_tag[s.wt[b]];
      i_wb_cls[b]  <= reg_class_t'(s.wc[b]);
    end
    i_done       <= s.done;
    i_done_idx   <= s.didx;
    i_replay     <= s.rep;
    i_replay_idx <= s.ridx;
  endtask

  // predict this cycle's outputs, compare, then step the model to the next edge
  task automatic check_and_advance(input step_t s);
    int   iss;
    int   ret;
    int   free_idx;
    int   sel;
    logic full;
    logic h1 [`RSV_ENTRY_NUM];
    logic h2 [`RSV_ENTRY_NUM];
    iss      = -1;
    ret      = -1;
    free_idx = -1;
    full     = 1'b1;
    for (int i = 0; i < `RSV_ENTRY_NUM; i++) begin
      h1[i] = wb_hits(s, m_rs1[i], m_c1[i]);
      h2[i] = wb_hits(s, m_rs2[i], m_c2[i]);
      if ((m_state[i] == ST_WAIT) && (!m_v1[i] || m_r1[i] || h1[i]) &&
          (m_store[i] || !m_v2[i] || m_r2[i] || h2[i]) && (iss < 0)) iss = i;
      if (m_state[i] == ST_DONE) ret = i;
      if (m_state[i] == ST_FREE) begin
        full = 1'b0;
        if (free_idx < 0) free_idx = i;
      end
    end
    if (s.exp_iss !== (iss >= 0)) begin
      report_mismatch("table issue against model issue", int'(s.exp_iss), int'(iss >= 0));
    end
    sel = (iss < 0) ? 0 : iss;
    check_issue(iss >= 0, entry_idx_t'(sel), m_cmt[sel], m_rd[sel], m_store[sel]);
    sel = (ret < 0) ? 0 : ret;
    check_retire(ret >= 0, m_cmt[sel]);
    check_full(full);
    for (int i = 0; i < `RSV_ENTRY_NUM; i++) begin
      case (m_state[i])
        ST_WAIT: begin
          m_r1[i] = m_r1[i] | h1[i];
          m_r2[i] = m_r2[i] | h2[i];
          if (i == iss) m_state[i] = ST_ISSUED;
        end
        ST_ISSUED: begin
          if (s.rep && (s.ridx == entry_idx_t'(i))) m_state[i] = ST_WAIT;  // replay wins
          else if (s.done && (s.didx == entry_idx_t'(i))) m_state[i] = ST_DONE;
        end
        ST_DONE: m_state[i] = ST_FREE;
        default: ;
      endcase
    end
    if (s.disp && (free_idx < 0)) begin
      $display("stimulus table dispatches into a full station at %0t ns", $time);
      n_errors++;
      test_errs++;
    end else if (s.disp) begin
      m_state[free_idx] = ST_WAIT;
      m_cmt[free_idx]   = s.cmt;
      m_rd[free_idx]    = s.rd;
      m_store[free_idx] = s.store;
      m_v1[free_idx]    = s.v1;
      m_rs1[free_idx]   = p_tag[s.t1];
      m_c1[free_idx]    = s.c1;
      m_v2[free_idx]    = s.v2;
      m_rs2[free_idx]   = p_tag[s.t2];
      m_c2[free_idx]    = s.c2;
      m_r1[free_idx]    = wb_hits(s, p_tag[s.t1], s.c1);  // same-cycle wakeup
      m_r2[free_idx]    = wb_hits(s, p_tag[s.t2], s.c2);
    end
  endtask

  initial begin
    int unsigned base;
    void'($urandom(32'h24a3));
    base = $urandom;
    for (int i = 0; i < 8; i++) p_tag[i] = rnid_t'(base + i);  // distinct tags
    for (int i = 0; i < `RSV_ENTRY_NUM; i++) begin
      m_state[i] = ST_FREE;
      m_cmt[i]   = '0;
      m_rd[i]    = '0;
      m_rs1[i]   = '0;
      m_rs2[i]   = '0;
      m_c1[i]    = CLS_INT;
      m_c2[i]    = CLS_INT;
      m_store[i] = 1'b0;
      m_v1[i]    = 1'b0;
      m_v2[i]    = 1'b0;
      m_r1[i]    = 1'b0;
      m_r2[i]    = 1'b0;
    end
    i_clk     = 1'b0;
    i_reset_n <= 1'b0;
    stg       = '0;
    drive_step(stg);

    stage_dispatch(4'd1, 1'b0, 5'd3, 1'b0, 0, CLS_INT, 1'b0, 0, CLS_INT);
    push_step(1, 1'b0);
    push_step(1, 1'b1);
    mark_done(0);
    push_step(1, 1'b0);
    push_step(1, 1'b0);

    stage_dispatch(4'd2, 1'b0, 5'd4, 1'b1, 0, CLS_INT, 1'b1, 1, CLS_FP);
    add_writeback(0, 0, CLS_INT);
    push_step(2, 1'b0);
    add_writeback(1, 1, CLS_INT);  // wrong class
    push_step(2, 1'b0);
    add_writeback(1, 1, CLS_FP);
    push_step(2, 1'b1);
    mark_done(0);
    push_step(2, 1'b0);
    push_step(2, 1'b0);

    stage_dispatch(4'd3, 1'b1, 5'd5, 1'b1, 2, CLS_INT, 1'b1, 3, CLS_INT);
    push_step(3, 1'b0);
    stage_dispatch(4'd4, 1'b0, 5'd6, 1'b1, 2, CLS_INT, 1'b1, 3, CLS_INT);
    add_writeback(0, 2, CLS_INT);
    push_step(3, 1'b1);
    push_step(3, 1'b0);
    mark_done(0);
    add_writeback(1, 3, CLS_INT);
    push_step(3, 1'b1);
    mark_done(1);
    push_step(3, 1'b0);
    push_step(3, 1'b0);

    stage_dispatch(4'd5, 1'b0, 5'd7, 1'b1, 4, CLS_INT, 1'b0, 0, CLS_INT);
    push_step(4, 1'b0);
    stage_dispatch(4'd6, 1'b0, 5'd8, 1'b0, 0, CLS_INT, 1'b0, 0, CLS_INT);
    push_step(4, 1'b0);
    stage_dispatch(4'd7, 1'b0, 5'd9, 1'b0, 0, CLS_INT, 1'b0, 0, CLS_INT);
    add_writeback(0, 4, CLS_INT);
    push_step(4, 1'b1);
    push_step(4, 1'b1);
    mark_done(0);
    push_step(4, 1'b1);
    mark_done(1);
    push_step(4, 1'b0);
    mark_done(2);
    push_step(4, 1'b0);
    push_step(4, 1'b0);

    stage_dispatch(4'd8, 1'b0, 5'd10, 1'b0, 0, CLS_INT, 1'b0, 0, CLS_INT);
    push_step(5, 1'b0);
    stage_dispatch(4'd9, 1'b0, 5'd11, 1'b1, 5, CLS_FP, 1'b0, 0, CLS_INT);
    push_step(5, 1'b1);
    mark_replay(0);
    push_step(5, 1'b0);
    stage_dispatch(4'd10, 1'b0, 5'd12, 1'b1, 6, CLS_INT, 1'b0, 0, CLS_INT);
    push_step(5, 1'b1);
    stage_dispatch(4'd11, 1'b0, 5'd13, 1'b1, 7, CLS_INT, 1'b0, 0, CLS_INT);
    push_step(5, 1'b0);
    mark_done(0);
    mark_replay(0);
    push_step(5, 1'b0);
    push_step(5, 1'b1);
    mark_done(0);
    push_step(5, 1'b0);
    push_step(5, 1'b0);
    push_step(5, 1'b0);

    cycle_limit = steps.size() + 50;
    repeat (10) @(posedge i_clk);
    i_reset_n   <= 1'b1;
    run_started = 1'b1;

    for (int k = 0; k < steps.size(); k++) begin
      @(posedge i_clk);
      drive_step(steps[k]);
      @(negedge i_clk);  // outputs settled mid-cycle
      check_and_advance(steps[k]);
      if ((k == steps.size() - 1) || (steps[k + 1].test != steps[k].test)) begin
        $display("test %0d (%s) finished with %0d errors", steps[k].test,
                 test_name(int'(steps[k].test)), test_errs);
        n_tests++;
        test_errs = 0;
      end
    end

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
